// ==== Bender.yml ====
package:
  name: seven_seg_anim

sources:
  - anim_pkg.sv
  - seg_pkg.sv
  - frame_timer.sv
  - anim_sequencer.sv
  - segment_decoder.sv
  - anim_top.sv
  - target: test
    files:
      - anim_checker.sv
      - tb_anim_top.sv

// ==== anim_checker.sv ====
module anim_checker #(
    parameter int MAX_COUNT  = 7,
    parameter int RATE_SHIFT = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       ena,
    input  logic [7:0] switches,
    input  logic [6:0] segments,
    input  logic [3:0] frame_idx,
    output int         errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // frames per loop, indexed by animation number
    localparam int LOOP_LEN [8] = '{10, 6, 6, 6, 4, 4, 2, 1};

    // expected display, ten slots per animation, gfedcba, slots past the loop stay dark
    localparam logic [6:0] PAT [80] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f,  // digits
        7'h01, 7'h02, 7'h04, 7'h08, 7'h10, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00,  // spin a..f
        7'h20, 7'h10, 7'h08, 7'h04, 7'h02, 7'h01, 7'h00, 7'h00, 7'h00, 7'h00,  // spin f..a
        7'h03, 7'h06, 7'h0c, 7'h18, 7'h30, 7'h21, 7'h00, 7'h00, 7'h00, 7'h00,  // pair spin
        7'h01, 7'h40, 7'h08, 7'h49, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,  // bars
        7'h22, 7'h14, 7'h36, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,  // verticals
        7'h40, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,  // blink
        7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00   // blank
    };

    bit         started   = 1'b0;   // set by the first reset seen
    int         err_count = 0;
    int         m_count;            // model of the frame timer
    bit         m_restart;          // model is in its restart cycle
    int         m_prev;             // animation seen last enabled cycle
    int         m_frame;
    logic [6:0] m_seg;              // display expected after the coming edge
    int         anim;
    int         cmp;
    bit         m_tick;

    assign errors = err_count;

    task automatic report_mismatch(input string name, input logic [7:0] exp,
                                   input logic [7:0] act);
        err_count++;
        $display("Error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
    endtask

    // negedge, so inputs and outputs are both settled
    always @(negedge clk) begin
        if (started) begin
            if (frame_idx !== 4'(m_frame)) begin
                report_mismatch("frame_idx", 8'(m_frame), {4'b0, frame_idx});
            end
            if (segments !== m_seg) begin
                report_mismatch("segments", {1'b0, m_seg}, {1'b0, segments});
            end
        end
        if (reset) begin
            m_count   = 0;
            m_restart = 1'b1;     // first cycle out of reset restarts
            m_prev    = 0;
            m_frame   = 0;
            m_seg     = 7'h00;
            started   = 1'b1;
        end else if (started) begin
            anim   = int'(switches[7:5]);
            cmp    = (switches == 8'd0) ? MAX_COUNT : (int'(switches) << RATE_SHIFT);
            m_tick = ena && !m_restart && (m_count >= cmp);
            m_seg  = PAT[anim * 10 + m_frame];   // display lags frame and anim by one
            // timer
            if (m_restart || m_tick) begin
                m_count = 0;
            end else if (ena) begin
                m_count++;
            end
            // sequencer, everything holds with ena low
            if (ena) begin
                if (m_restart) begin
                    m_restart = 1'b0;
                    m_frame   = 0;
                end else if (anim != m_prev) begin
                    m_restart = 1'b1;   // new selection, one restart cycle
                    m_frame   = 0;
                end else if (m_tick) begin
                    m_frame = (m_frame >= LOOP_LEN[anim] - 1) ? 0 : m_frame + 1;
                end
                m_prev = anim;
            end
        end
    end

endmodule

// ==== anim_pkg.sv ====
package anim_pkg;

    // animation number, top three switch bits
    typedef logic [2:0] anim_sel_t;

    // frame index within one animation, longest loop is ten frames
    typedef logic [3:0] frame_idx_t;

    // one switch byte, read two ways
    // the whole byte sets the frame rate, the top bits also pick the animation
    typedef union packed {
        logic [7:0] rate;             // full word as rate value, 0 means default period
        struct packed {
            anim_sel_t  anim;         // bits 7:5
            logic [4:0] unused;       // low bits only matter as rate
        } fields;
    } switch_word_u;

    // last frame of each loop, the sequencer wraps to 0 after it
    function automatic frame_idx_t last_frame(input anim_sel_t anim);
        frame_idx_t last;
        case (anim)
            3'd0:             last = 4'd9;   // decimal digits
            3'd1, 3'd2, 3'd3: last = 4'd5;   // ring spins, six outer segments
            3'd4, 3'd5:       last = 4'd3;   // bar patterns
            3'd6:             last = 4'd1;   // blink
            default:          last = 4'd0;   // blank, single frame
        endcase
        return last;
    endfunction

endpackage

// ==== anim_sequencer.sv ====
module anim_sequencer
    import anim_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ena,
    input  logic       tick,      // frame period done
    input  anim_sel_t  anim,      // selected animation
    output logic       restart,   // to the timer
    output frame_idx_t frame
);

    localparam logic ST_RESTART = 1'b0;
    localparam logic ST_PLAY    = 1'b1;

    logic      state;
    anim_sel_t prev_anim;      // animation seen last enabled cycle
    logic      anim_changed;
    frame_idx_t last;          // wrap point of the current loop

    assign anim_changed = (anim != prev_anim);
    assign last         = last_frame(anim);

    // timer is held at zero while we sit in RESTART
    assign restart = (state == ST_RESTART);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_RESTART;   // first cycle out of reset restarts the timer
            prev_anim <= '0;
            frame     <= '0;
        end else if (ena) begin
            prev_anim <= anim;
            case (state)
                ST_RESTART: begin
                    // single cycle, tick is suppressed here so no step
                    state <= ST_PLAY;
                    frame <= '0;
                end
                default: begin
                    if (anim_changed) begin
                        // new selection wins over a tick in the same cycle
                        state <= ST_RESTART;
                        frame <= '0;
                    end else if (tick) begin
                        if (frame >= last) begin
                            frame <= '0;            // loop wrap
                        end else begin
                            frame <= frame + 4'd1;
                        end
                    end
                end
            endcase
        end
        // ena low, state and frame hold, change is picked up once ena returns
    end

    // frame was last stepped under prev_anim, so that loop length bounds it
    // (right at a change anim is already new while frame still belongs to the old loop)
    a_frame_in_range: assert property (
        @(posedge clk) disable iff (reset)
        frame <= last_frame(prev_anim)
    ) else $error("anim_sequencer: frame %0d past last frame of anim %0d", frame, prev_anim);

    // RESTART takes exactly one enabled cycle, then PLAY
    a_restart_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        (restart && ena) |=> !restart
    ) else $error("anim_sequencer: RESTART held longer than one cycle");

endmodule

// ==== anim_top.sv ====
module anim_top
    import anim_pkg::*;
    import seg_pkg::*;
#(
    parameter logic [23:0] MAX_COUNT  = 24'd10_000_000,   // default frame period
    parameter int unsigned RATE_SHIFT = 10                 // rate to compare scaling
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       ena,
    input  logic [7:0] switches,
    output seg_word_t  segments,
    output frame_idx_t frame_idx   // debug view of the running frame
);

    switch_word_u sw;        // one switch byte, rate view and field view
    anim_sel_t    anim;
    logic         tick;
    logic         restart;
    frame_idx_t   frame;

    assign sw.rate   = switches;
    assign anim      = sw.fields.anim;   // top three bits pick the loop
    assign frame_idx = frame;

    frame_timer #(
        .MAX_COUNT  (MAX_COUNT),
        .RATE_SHIFT (RATE_SHIFT)
    ) timer_i (
        .clk     (clk),
        .reset   (reset),
        .ena     (ena),
        .restart (restart),
        .rate    (sw.rate),      // whole byte, animation bits included
        .tick    (tick)
    );

    anim_sequencer seq_i (
        .clk     (clk),
        .reset   (reset),
        .ena     (ena),
        .tick    (tick),
        .anim    (anim),
        .restart (restart),
        .frame   (frame)
    );

    segment_decoder dec_i (
        .clk      (clk),
        .reset    (reset),
        .anim     (anim),
        .frame    (frame),
        .segments (segments)
    );

endmodule

// ==== files.f ====
anim_pkg.sv
seg_pkg.sv
frame_timer.sv
anim_sequencer.sv
segment_decoder.sv
anim_top.sv
anim_checker.sv
tb_anim_top.sv

// ==== frame_timer.sv ====
module frame_timer #(
    parameter logic [23:0] MAX_COUNT  = 24'd10_000_000,   // period when rate is 0
    parameter int unsigned RATE_SHIFT = 10                 // rate scaling
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       ena,
    input  logic       restart,   // from the sequencer, zeroes the count
    input  logic [7:0] rate,
    output logic       tick       // one cycle per frame
);

    logic [23:0] count;
    logic [23:0] compare;

    // nonzero rate overrides the built-in period
    assign compare = (rate == 8'd0) ? MAX_COUNT : ({16'd0, rate} << RATE_SHIFT);

    // period is compare + 1 enabled cycles
    // >= so a rate drop below the running count ends the frame at once
    assign tick = ena && !restart && (count >= compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;             // new animation starts a full period
        end else if (tick) begin
            count <= '0;
        end else if (ena) begin
            count <= count + 24'd1;
        end
        // ena low, count holds
    end

    // tick must never slip through a restart or a disabled cycle,
    // the sequencer would step a frame it is about to clear
    a_tick_qualified: assert property (
        @(posedge clk) disable iff (reset)
        tick |-> (ena && !restart)
    ) else $error("frame_timer: tick with restart high or ena low");

endmodule

// ==== seg_pkg.sv ====
package seg_pkg;
    import anim_pkg::*;

    // segments a..g, bit 0 is a, active high
    typedef logic [6:0] seg_word_t;

    localparam seg_word_t SEG_BLANK = 7'b000_0000;
    localparam seg_word_t SEG_G     = 7'b100_0000;   // middle bar only

    // digit shapes, gfedcba
    localparam seg_word_t DIGIT_PAT [10] = '{
        7'b011_1111, 7'b000_0110, 7'b101_1011, 7'b100_1111, 7'b110_0110,
        7'b110_1101, 7'b111_1101, 7'b000_0111, 7'b111_1111, 7'b110_1111
    };

    // segment pattern of one frame, anything past the loop end shows blank
    function automatic seg_word_t frame_pattern(input anim_sel_t anim, input frame_idx_t frame);
        logic [11:0] pair;   // two lit bits, doubled ring so f wraps onto a
        seg_word_t   pat;
        pair = 12'b0000_0000_0011 << frame;
        pat  = SEG_BLANK;
        case (anim)
            3'd0: if (frame <= 4'd9) pat = DIGIT_PAT[frame];
            3'd1: if (frame <= 4'd5) pat = 7'b000_0001 << frame;   // a b c d e f
            3'd2: if (frame <= 4'd5) pat = 7'b010_0000 >> frame;   // f e d c b a
            3'd3: if (frame <= 4'd5) pat = {1'b0, pair[5:0] | pair[11:6]};
            3'd4: begin
                case (frame)
                    4'd0:    pat = 7'b000_0001;   // a
                    4'd1:    pat = 7'b100_0000;   // g
                    4'd2:    pat = 7'b000_1000;   // d
                    4'd3:    pat = 7'b100_1001;   // all three bars
                    default: pat = SEG_BLANK;
                endcase
            end
            3'd5: begin
                case (frame)
                    4'd0:    pat = 7'b010_0010;   // f and b
                    4'd1:    pat = 7'b001_0100;   // e and c
                    4'd2:    pat = 7'b011_0110;   // all four verticals
                    default: pat = SEG_BLANK;     // frame 3 is the dark one
                endcase
            end
            3'd6: if (frame == 4'd0) pat = SEG_G;   // g on, then off
            default: pat = SEG_BLANK;
        endcase
        return pat;
    endfunction

endpackage

// ==== segment_decoder.sv ====
module segment_decoder
    import anim_pkg::*;
    import seg_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  anim_sel_t  anim,
    input  frame_idx_t frame,
    output seg_word_t  segments   // registered, active high, bit 0 is a
);

    seg_word_t next_segments;

    // pattern lookup is pure combinational, table lives in seg_pkg
    assign next_segments = frame_pattern(anim, frame);

    // one cycle behind frame and anim, no ena gating
    // (frame already holds while disabled, so the display holds too)
    always_ff @(posedge clk) begin
        if (reset) begin
            segments <= SEG_BLANK;   // dark until the first update
        end else begin
            segments <= next_segments;
        end
    end

    // blank animation must stay dark whatever frame the sequencer carries,
    // including the cycle before its restart clears the old frame
    a_anim7_blank: assert property (
        @(posedge clk) disable iff (reset)
        (anim == 3'd7) |=> (segments == SEG_BLANK)
    ) else $error("segment_decoder: animation 7 not blank");

endmodule

// ==== tb_anim_top.sv ====
module tb_anim_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_COUNT  = 7;   // period 8 at rate 0
    localparam int RATE_SHIFT = 2;

    typedef struct packed {
        logic [7:0]  switches;
        logic        ena;
        logic [15:0] hold;    // cycles to apply the row
        logic [3:0]  frame;   // expected frame_idx at the end
        logic        check;   // random rows have no table value
    } row_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       ena;
    logic [7:0] switches;
    logic [6:0] segments;
    logic [3:0] frame_idx;
    row_t       rows[$];
    int         table_errors = 0;
    int         model_errors;
    int         limit_cycles = 0;

    always #4 clk = ~clk;   // 8 ns period

    anim_top #(
        .MAX_COUNT  (24'(MAX_COUNT)),
        .RATE_SHIFT (RATE_SHIFT)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .ena       (ena),
        .switches  (switches),
        .segments  (segments),
        .frame_idx (frame_idx)
    );

    anim_checker #(
        .MAX_COUNT  (MAX_COUNT),
        .RATE_SHIFT (RATE_SHIFT)
    ) chk_i (
        .clk       (clk),
        .reset     (reset),
        .ena       (ena),
        .switches  (switches),
        .segments  (segments),
        .frame_idx (frame_idx),
        .errors    (model_errors)
    );

    task automatic add_row(input logic [7:0] sw, input logic en, input int hold,
                           input int exp_frame, input logic chk);
        row_t r;
        r.switches = sw;
        r.ena      = en;
        r.hold     = 16'(hold);
        r.frame    = 4'(exp_frame);
        r.check    = chk;
        rows.push_back(r);
    endtask

    initial begin
        int unsigned seed;
        int unsigned rnd;
        row_t        r;
        int          total;
        reset    = 1'b1;
        ena      = 1'b1;
        switches = 8'h00;
        seed     = 32'h32ad_d394;
        rnd      = $urandom(seed);   // seeds the generator once
        // default period 8, digits through a full wrap
        add_row(8'h00, 1'b1, 9, 1, 1'b1);
        add_row(8'h00, 1'b1, 64, 9, 1'b1);
        add_row(8'h00, 1'b1, 8, 0, 1'b1);
        // freeze mid-period, count resumes where it stopped
        add_row(8'h00, 1'b1, 4, 0, 1'b1);
        add_row(8'h00, 1'b0, 20, 0, 1'b1);
        add_row(8'h00, 1'b1, 4, 1, 1'b1);
        // rate 3, period 13
        add_row(8'h03, 1'b1, 13, 2, 1'b1);
        add_row(8'h03, 1'b1, 13, 3, 1'b1);
        add_row(8'h03, 1'b1, 6, 3, 1'b1);
        // change mid-period, first step lands on cycle compare + 3 from the edge
        add_row(8'h20, 1'b1, 130, 0, 1'b1);
        add_row(8'h20, 1'b1, 1, 1, 1'b1);
        add_row(8'h20, 1'b1, 516, 5, 1'b1);
        add_row(8'h20, 1'b1, 129, 0, 1'b1);
        add_row(8'h40, 1'b1, 259, 1, 1'b1);   // compare 256
        add_row(8'h40, 1'b1, 1028, 5, 1'b1);
        add_row(8'h40, 1'b1, 257, 0, 1'b1);
        add_row(8'h60, 1'b1, 387, 1, 1'b1);   // compare 384
        add_row(8'h60, 1'b1, 1540, 5, 1'b1);
        add_row(8'h60, 1'b1, 385, 0, 1'b1);
        add_row(8'h80, 1'b1, 515, 1, 1'b1);   // bars, four frames
        add_row(8'h80, 1'b1, 1026, 3, 1'b1);
        add_row(8'h80, 1'b1, 513, 0, 1'b1);
        add_row(8'ha0, 1'b1, 643, 1, 1'b1);
        add_row(8'ha0, 1'b1, 1282, 3, 1'b1);
        add_row(8'ha0, 1'b1, 641, 0, 1'b1);
        add_row(8'hc0, 1'b1, 771, 1, 1'b1);   // blink
        add_row(8'hc0, 1'b1, 769, 0, 1'b1);
        add_row(8'he0, 1'b1, 900, 0, 1'b1);   // blank wraps onto itself
        // random words, ena mostly high
        for (int i = 0; i < 8; i++) begin
            add_row(8'($urandom), ($urandom % 4) != 0, 200, 0, 1'b0);
        end
        total = 0;
        foreach (rows[i]) begin
            total += int'(rows[i].hold);
        end
        limit_cycles = total + 50;   // all hold cycles plus margin
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        foreach (rows[i]) begin
            r        = rows[i];
            switches = r.switches;
            ena      = r.ena;
            repeat (int'(r.hold)) @(posedge clk);
            #1;
            if (r.check && frame_idx !== r.frame) begin
                table_errors++;
                $display("Error: time %0t signal frame_idx expected %h actual %h",
                         $time, r.frame, frame_idx);
            end
        end
        repeat (2) @(negedge clk);   // let the checker see the last display update
        $display("table errors %0d, checker errors %0d", table_errors, model_errors);
        if (table_errors == 0 && model_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog, limit known once the table is built
    initial begin
        wait (limit_cycles != 0);
        #(limit_cycles * 8);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
